// File: hdl/csr_pkg.sv
// shared CSR definitions; addresses follow the core's custom map, UART status is a constant
package csr_pkg;

  // csr instruction flavour, low two funct3 bits
  typedef enum logic [1:0] {
    csr_read = 2'b00,
    csr_rw   = 2'b01,
    csr_rs   = 2'b10,
    csr_rc   = 2'b11
  } csr_op_e;

  // counters
  localparam logic [11:0] addr_mcycle    = 12'hB00;
  localparam logic [11:0] addr_minstret  = 12'hB02;
  localparam logic [11:0] addr_mcycleh   = 12'hB80;
  localparam logic [11:0] addr_minstreth = 12'hB82;

  // uart
  localparam logic [11:0] addr_muartstat = 12'hFC0;
  localparam logic [11:0] addr_muarttx   = 12'h7C0;

  // accelerator window 0x7D0..0x7DF
  localparam logic [11:0] addr_mbfsstat  = 12'h7D0;
  localparam logic [11:0] addr_mbfsroot  = 12'h7D1;
  localparam logic [11:0] addr_mbfstarg  = 12'h7D2;
  localparam logic [11:0] addr_mbfsqbase = 12'h7D3;
  localparam logic [11:0] addr_mbfsqsize = 12'h7D4;

  // l2 request flag
  localparam logic [11:0] addr_ml2stat   = 12'h7E0;

  // uart status bits
  localparam logic [31:0] uart_rxempty = 32'h0000_0001;
  localparam logic [31:0] uart_txempty = 32'h0000_0004;

  // tx always drained, rx path absent
  localparam logic [31:0] uartstat_value = uart_txempty | uart_rxempty;

  // tag widths
  localparam int robid_w = 7;
  localparam int rd_w    = 6;

endpackage

// File: hdl/csr_req_fifo.sv
// in-order CSR request queue; a push while full is dropped, so the writer must watch full
`timescale 1ns/1ps

module csr_req_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        push,
  input  csr_pkg::csr_op_e            push_op,
  input  logic [csr_pkg::robid_w-1:0] push_robid,
  input  logic [csr_pkg::rd_w-1:0]    push_rd,
  input  logic [31:0]                 push_op1,
  input  logic [11:0]                 push_addr,
  input  logic                        pop,
  output logic                        full,
  output logic                        head_valid,
  output csr_pkg::csr_op_e            head_op,
  output logic [csr_pkg::robid_w-1:0] head_robid,
  output logic [csr_pkg::rd_w-1:0]    head_rd,
  output logic [31:0]                 head_op1,
  output logic [11:0]                 head_addr
);
  import csr_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  csr_op_e            mem_op    [FIFO_DEPTH];
  logic [robid_w-1:0] mem_robid [FIFO_DEPTH];
  logic [rd_w-1:0]    mem_rd    [FIFO_DEPTH];
  logic [31:0]        mem_op1   [FIFO_DEPTH];
  logic [11:0]        mem_addr  [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full       = (count == CNT_W'(FIFO_DEPTH));
  assign head_valid = (count != '0);
  assign do_push    = push & ~full;
  assign do_pop     = pop & head_valid;

  // storage, no reset needed
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_op[wr_ptr]    <= push_op;
      mem_robid[wr_ptr] <= push_robid;
      mem_rd[wr_ptr]    <= push_rd;
      mem_op1[wr_ptr]   <= push_op1;
      mem_addr[wr_ptr]  <= push_addr;
    end
  end

  // depth need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  assign head_op    = mem_op[rd_ptr];
  assign head_robid = mem_robid[rd_ptr];
  assign head_rd    = mem_rd[rd_ptr];
  assign head_op1   = mem_op1[rd_ptr];
  assign head_addr  = mem_addr[rd_ptr];

endmodule

// File: hdl/csr_unit.sv
// single-stage CSR executor; no traps or flush, rs/rc into the accelerator window only flag an error
`timescale 1ns/1ps

module csr_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_valid,
  input  csr_pkg::csr_op_e            in_op,
  input  logic [csr_pkg::robid_w-1:0] in_robid,
  input  logic [csr_pkg::rd_w-1:0]    in_rd,
  input  logic [31:0]                 in_op1,
  input  logic [11:0]                 in_addr,
  output logic                        stall,
  input  logic                        ret_valid,
  input  logic                        ret_csr,
  input  logic                        l2_req,
  output logic                        bfs_req,
  output logic [3:0]                  bfs_addr,
  output logic                        bfs_wen,
  output logic [31:0]                 bfs_wdata,
  input  logic                        bfs_rsp_valid,
  input  logic                        bfs_rsp_error,
  input  logic [31:0]                 bfs_rdata,
  output logic                        wb_valid,
  output logic                        wb_error,
  output logic [csr_pkg::robid_w-1:0] wb_robid,
  output logic [csr_pkg::rd_w-1:0]    wb_rd,
  output logic [31:0]                 wb_result,
  output logic                        uart_tx_valid,
  output logic [7:0]                  uart_tx_data
);
  import csr_pkg::*;

  // staged instruction
  logic               valid;
  csr_op_e            op;
  logic [robid_w-1:0] robid;
  logic [rd_w-1:0]    rd;
  logic [31:0]        op1;
  logic [11:0]        addr;

  // architectural state
  logic [63:0] cycle_cnt;
  logic [63:0] instret_cnt;
  logic [63:0] cycle_nxt;
  logic [63:0] instret_nxt;
  logic [7:0]  muarttx;

  // one-hot address select
  logic sel_mcycle;
  logic sel_mcycleh;
  logic sel_minstret;
  logic sel_minstreth;
  logic sel_muartstat;
  logic sel_muarttx;
  logic sel_bfs;
  logic sel_ml2stat;
  logic sel_none;

  logic [31:0] rd_value;
  logic [31:0] wdata;
  logic        wen;
  logic        commit_wen;
  logic        ro_space;
  logic        bfs_setclr;
  logic        bfs_req_r;
  logic        l2_stall;
  logic        l2_stall_r;
  logic        inc_instret;

  always_ff @(posedge clk) begin
    if (rst)
      valid <= 1'b0;
    else if (!stall)
      valid <= in_valid;
  end

  always_ff @(posedge clk) begin
    if (!stall && in_valid) begin
      op    <= in_op;
      robid <= in_robid;
      rd    <= in_rd;
      op1   <= in_op1;
      addr  <= in_addr;
    end
  end

  always_comb begin
    sel_mcycle    = 1'b0;
    sel_mcycleh   = 1'b0;
    sel_minstret  = 1'b0;
    sel_minstreth = 1'b0;
    sel_muartstat = 1'b0;
    sel_muarttx   = 1'b0;
    sel_bfs       = 1'b0;
    sel_ml2stat   = 1'b0;
    sel_none      = 1'b0;
    case (addr)
      addr_mcycle:    sel_mcycle = 1'b1;
      addr_mcycleh:   sel_mcycleh = 1'b1;
      addr_minstret:  sel_minstret = 1'b1;
      addr_minstreth: sel_minstreth = 1'b1;
      addr_muartstat: sel_muartstat = 1'b1;
      addr_muarttx:   sel_muarttx = 1'b1;
      addr_ml2stat:   sel_ml2stat = 1'b1;
      default: begin
        // whole 0x7D? page belongs to the accelerator
        if (addr[11:4] == addr_mbfsstat[11:4])
          sel_bfs = 1'b1;
        else
          sel_none = 1'b1;
      end
    endcase
  end

  always_comb begin
    case (1'b1)
      sel_mcycle:    rd_value = cycle_cnt[31:0];
      sel_mcycleh:   rd_value = cycle_cnt[63:32];
      sel_minstret:  rd_value = instret_cnt[31:0];
      sel_minstreth: rd_value = instret_cnt[63:32];
      sel_muartstat: rd_value = uartstat_value;
      sel_muarttx:   rd_value = {24'b0, muarttx};
      sel_bfs:       rd_value = bfs_rdata;
      sel_ml2stat:   rd_value = {31'b0, l2_req};
      default:       rd_value = 32'b0;
    endcase
  end

  // read-modify-write data
  always_comb begin
    case (op)
      csr_rw:  wdata = op1;
      csr_rs:  wdata = rd_value | op1;
      csr_rc:  wdata = rd_value & ~op1;
      default: wdata = 32'b0;
    endcase
  end

  assign wen        = valid & (op != csr_read);
  assign commit_wen = wen & ~stall;
  assign ro_space   = &addr[11:10];
  assign bfs_setclr = sel_bfs & ((op == csr_rs) | (op == csr_rc));

  // accelerator port, one request per staged instruction
  assign bfs_req   = valid & sel_bfs & ~bfs_setclr & ~bfs_req_r;
  assign bfs_addr  = addr[3:0];
  assign bfs_wen   = wen;
  assign bfs_wdata = op1;

  always_ff @(posedge clk) begin
    if (rst)
      bfs_req_r <= 1'b0;
    else
      bfs_req_r <= bfs_req;
  end

  // hold an ML2STAT write until the cycle after l2_req drops
  assign l2_stall = wen & sel_ml2stat & l2_req;

  always_ff @(posedge clk) begin
    if (rst || !l2_req)
      l2_stall_r <= 1'b0;
    else if (wen && sel_ml2stat)
      l2_stall_r <= 1'b1;
  end

  assign stall = bfs_req | l2_stall | l2_stall_r;

  assign wb_valid  = valid & ~stall;
  assign wb_robid  = robid;
  assign wb_rd     = rd;
  assign wb_result = rd_value;
  assign wb_error  = sel_none | (wen & ro_space) | bfs_setclr |
                     (bfs_req_r & (~bfs_rsp_valid | bfs_rsp_error));

  // retire of the write itself must not bump the new value
  assign inc_instret = ret_valid & ~(ret_csr & wen & sel_minstret);

  always_comb begin
    cycle_nxt   = cycle_cnt + 64'd1;
    instret_nxt = instret_cnt + {63'b0, inc_instret};
    if (commit_wen) begin
      if (sel_mcycle)
        cycle_nxt[31:0] = wdata;
      if (sel_mcycleh)
        cycle_nxt[63:32] = wdata;
      if (sel_minstret)
        instret_nxt[31:0] = wdata;
      if (sel_minstreth)
        instret_nxt[63:32] = wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_cnt   <= 64'b0;
      instret_cnt <= 64'b0;
    end else begin
      cycle_cnt   <= cycle_nxt;
      instret_cnt <= instret_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      muarttx <= 8'b0;
    else if (commit_wen && sel_muarttx)
      muarttx <= wdata[7:0];
  end

  assign uart_tx_valid = commit_wen & sel_muarttx;
  assign uart_tx_data  = wdata[7:0];

endmodule

// File: hdl/bfs_csr_regs.sv
// BFS accelerator config block; answers each request exactly one cycle later, offsets 5-15 unmapped
`timescale 1ns/1ps

module bfs_csr_regs (
  input  logic        clk,
  input  logic        rst,
  input  logic        req,
  input  logic [3:0]  addr,
  input  logic        wen,
  input  logic [31:0] wdata,
  output logic        rsp_valid,
  output logic        rsp_error,
  output logic [31:0] rdata
);

  localparam logic [3:0] OFF_STAT  = 4'd0;
  localparam logic [3:0] OFF_ROOT  = 4'd1;
  localparam logic [3:0] OFF_TARG  = 4'd2;
  localparam logic [3:0] OFF_QBASE = 4'd3;
  localparam logic [3:0] OFF_QSIZE = 4'd4;

  logic [31:0] root;
  logic [31:0] targ;
  logic [31:0] qbase;
  logic [31:0] qsize;

  always_ff @(posedge clk) begin
    if (rst)
      rsp_valid <= 1'b0;
    else
      rsp_valid <= req;
  end

  // read data is the value before this access's write
  always_ff @(posedge clk) begin
    if (req) begin
      rsp_error <= 1'b0;
      case (addr)
        OFF_STAT: begin
          rdata     <= {31'b0, root != targ};
          rsp_error <= wen;
        end
        OFF_ROOT:  rdata <= root;
        OFF_TARG:  rdata <= targ;
        OFF_QBASE: rdata <= qbase;
        OFF_QSIZE: rdata <= qsize;
        default: begin
          rdata     <= 32'b0;
          rsp_error <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      root  <= 32'b0;
      targ  <= 32'b0;
      qbase <= 32'b0;
      qsize <= 32'b0;
    end else if (req && wen) begin
      case (addr)
        OFF_ROOT:  root <= wdata;
        OFF_TARG:  targ <= wdata;
        OFF_QBASE: qbase <= wdata;
        OFF_QSIZE: qsize <= wdata;
        default: ;
      endcase
    end
  end

endmodule

// File: hdl/csr_top.sv
// CSR subsystem top; rename must not assert req_valid while req_full is high
`timescale 1ns/1ps

module csr_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        req_valid,
  input  csr_pkg::csr_op_e            req_op,
  input  logic [csr_pkg::robid_w-1:0] req_robid,
  input  logic [csr_pkg::rd_w-1:0]    req_rd,
  input  logic [31:0]                 req_op1,
  input  logic [31:0]                 req_imm,
  output logic                        req_full,
  input  logic                        rob_ret_valid,
  input  logic                        rob_ret_csr,
  input  logic                        l2_req,
  output logic                        wb_valid,
  output logic                        wb_error,
  output logic [csr_pkg::robid_w-1:0] wb_robid,
  output logic [csr_pkg::rd_w-1:0]    wb_rd,
  output logic [31:0]                 wb_result,
  output logic                        uart_tx_valid,
  output logic [7:0]                  uart_tx_data
);
  import csr_pkg::*;

  // queue head
  logic               q_valid;
  csr_op_e            q_op;
  logic [robid_w-1:0] q_robid;
  logic [rd_w-1:0]    q_rd;
  logic [31:0]        q_op1;
  logic [11:0]        q_addr;
  logic               csr_stall;

  // accelerator port
  logic        bfs_req;
  logic [3:0]  bfs_addr;
  logic        bfs_wen;
  logic [31:0] bfs_wdata;
  logic        bfs_rsp_valid;
  logic        bfs_rsp_error;
  logic [31:0] bfs_rdata;

  // only the csr address field of the immediate is kept
  csr_req_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk        (clk),
    .rst        (rst),
    .push       (req_valid),
    .push_op    (req_op),
    .push_robid (req_robid),
    .push_rd    (req_rd),
    .push_op1   (req_op1),
    .push_addr  (req_imm[11:0]),
    .pop        (~csr_stall),
    .full       (req_full),
    .head_valid (q_valid),
    .head_op    (q_op),
    .head_robid (q_robid),
    .head_rd    (q_rd),
    .head_op1   (q_op1),
    .head_addr  (q_addr)
  );

  csr_unit u_csr (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (q_valid),
    .in_op         (q_op),
    .in_robid      (q_robid),
    .in_rd         (q_rd),
    .in_op1        (q_op1),
    .in_addr       (q_addr),
    .stall         (csr_stall),
    .ret_valid     (rob_ret_valid),
    .ret_csr       (rob_ret_csr),
    .l2_req        (l2_req),
    .bfs_req       (bfs_req),
    .bfs_addr      (bfs_addr),
    .bfs_wen       (bfs_wen),
    .bfs_wdata     (bfs_wdata),
    .bfs_rsp_valid (bfs_rsp_valid),
    .bfs_rsp_error (bfs_rsp_error),
    .bfs_rdata     (bfs_rdata),
    .wb_valid      (wb_valid),
    .wb_error      (wb_error),
    .wb_robid      (wb_robid),
    .wb_rd         (wb_rd),
    .wb_result     (wb_result),
    .uart_tx_valid (uart_tx_valid),
    .uart_tx_data  (uart_tx_data)
  );

  bfs_csr_regs u_bfs_regs (
    .clk       (clk),
    .rst       (rst),
    .req       (bfs_req),
    .addr      (bfs_addr),
    .wen       (bfs_wen),
    .wdata     (bfs_wdata),
    .rsp_valid (bfs_rsp_valid),
    .rsp_error (bfs_rsp_error),
    .rdata     (bfs_rdata)
  );

endmodule

// File: tb/csr_sva.sv
// protocol assertions bound into csr_top, since the push side is not visible inside csr_unit
`timescale 1ns/1ps

module csr_sva (
  input logic clk,
  input logic rst,
  input logic req_valid,
  input logic req_full,
  input logic csr_stall,
  input logic bfs_req,
  input logic bfs_rsp_valid,
  input logic wb_valid
);

  // accelerator request is a one-cycle pulse
  bfs_req_single: assert property (@(posedge clk) disable iff (rst)
    bfs_req |=> !bfs_req)
    else $error("bfs_req high for two cycles in a row");

  bfs_rsp_follows: assert property (@(posedge clk) disable iff (rst)
    bfs_req |=> bfs_rsp_valid)
    else $error("bfs response missing one cycle after request");

  bfs_rsp_only_after_req: assert property (@(posedge clk) disable iff (rst)
    bfs_rsp_valid |-> $past(bfs_req))
    else $error("bfs response without a request one cycle earlier");

  no_wb_in_stall: assert property (@(posedge clk) disable iff (rst)
    csr_stall |-> !wb_valid)
    else $error("writeback while the CSR unit stalls");

  no_push_when_full: assert property (@(posedge clk) disable iff (rst)
    req_full |-> !req_valid)
    else $error("request pushed into a full queue");

endmodule

bind csr_top csr_sva u_sva (
  .clk           (clk),
  .rst           (rst),
  .req_valid     (req_valid),
  .req_full      (req_full),
  .csr_stall     (csr_stall),
  .bfs_req       (bfs_req),
  .bfs_rsp_valid (bfs_rsp_valid),
  .wb_valid      (wb_valid)
);

// File: tb/csr_tb.sv
// self-checking testbench for csr_top; fixed seed, model assumes rename never pushes while full
`timescale 1ns/1ps

module csr_tb;
  import csr_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int NUM_INSTR  = 400;
  localparam int TIMEOUT    = NUM_INSTR * 12 + 200;

  logic               clk;
  logic               rst;
  logic               req_valid;
  csr_op_e            req_op;
  logic [robid_w-1:0] req_robid;
  logic [rd_w-1:0]    req_rd;
  logic [31:0]        req_op1;
  logic [31:0]        req_imm;
  logic               req_full;
  logic               rob_ret_valid;
  logic               rob_ret_csr;
  logic               l2_req;
  logic               wb_valid;
  logic               wb_error;
  logic [robid_w-1:0] wb_robid;
  logic [rd_w-1:0]    wb_rd;
  logic [31:0]        wb_result;
  logic               uart_tx_valid;
  logic [7:0]         uart_tx_data;

  integer seed;
  int     err_count;
  int     sent;
  int     done_cnt;
  int     in_flight;
  int     cyc;
  bit     full_seen;

  // {op, addr, op1, robid, rd} in push order
  logic [58:0] exp_q[$];

  // shadow state
  logic [63:0] m_cycle;
  logic [63:0] m_instret;
  logic [7:0]  m_uart;
  logic [31:0] m_root;
  logic [31:0] m_targ;
  logic [31:0] m_qbase;
  logic [31:0] m_qsize;

  csr_top #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) uut (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_robid     (req_robid),
    .req_rd        (req_rd),
    .req_op1       (req_op1),
    .req_imm       (req_imm),
    .req_full      (req_full),
    .rob_ret_valid (rob_ret_valid),
    .rob_ret_csr   (rob_ret_csr),
    .l2_req        (l2_req),
    .wb_valid      (wb_valid),
    .wb_error      (wb_error),
    .wb_robid      (wb_robid),
    .wb_rd         (wb_rd),
    .wb_result     (wb_result),
    .uart_tx_valid (uart_tx_valid),
    .uart_tx_data  (uart_tx_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic issue_request();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] addr;
    r = $random(seed);
    a = $random(seed);
    b = $random(seed);
    case (r[3:0])
      4'd0:    addr = addr_mcycle;
      4'd1:    addr = addr_mcycleh;
      4'd2:    addr = addr_minstret;
      4'd3:    addr = addr_minstreth;
      4'd4:    addr = addr_muartstat;
      4'd5:    addr = addr_muarttx;
      4'd6:    addr = addr_ml2stat;
      4'd7:    addr = addr_mbfsstat;
      4'd8:    addr = addr_mbfsroot;
      4'd9:    addr = addr_mbfstarg;
      4'd10:   addr = addr_mbfsqbase;
      4'd11:   addr = addr_mbfsqsize;
      4'd12:   addr = {8'h7D, b[3:0]};
      4'd13:   addr = {4'h3, b[7:0]};
      default: addr = b[11:0];
    endcase
    req_valid = 1'b1;
    req_op    = csr_op_e'(r[5:4]);
    req_robid = sent[robid_w-1:0];
    req_rd    = b[17:12];
    // small operands make root == target likely now and then
    req_op1   = r[8] ? {28'h0, a[3:0]} : a;
    req_imm   = {b[31:12], addr};
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r = $random(seed);
    req_valid = 1'b0;
    if (rst) begin
      rob_ret_valid = 1'b0;
      rob_ret_csr   = 1'b0;
      l2_req        = 1'b0;
    end else begin
      rob_ret_valid = r[0];
      rob_ret_csr   = r[1] & r[2];
      if (r[7:3] == 5'd0)
        l2_req = ~l2_req;
      if (sent < NUM_INSTR && !req_full && r[9:8] != 2'b00)
        issue_request();
    end
  endtask

  // models the coming rising edge from current inputs and state
  task automatic model_cycle();
    logic [1:0]         op;
    logic [11:0]        addr;
    logic [31:0]        op1;
    logic [robid_w-1:0] rb;
    logic [rd_w-1:0]    rdv;
    logic [31:0]        old_val;
    logic [31:0]        new_val;
    logic               wr;
    logic               exp_err;
    logic               chk_result;
    logic               exp_tx;
    logic               exp_full;
    logic [63:0]        cycle_nxt;
    logic [63:0]        instret_nxt;
    exp_tx      = 1'b0;
    cycle_nxt   = m_cycle + 64'd1;
    instret_nxt = m_instret + {63'h0, rob_ret_valid};
    if (rst) begin
      if (wb_valid !== 1'b0 || uut.bfs_req !== 1'b0 || uart_tx_valid !== 1'b0 ||
          req_full !== 1'b0) begin
        $display("Mismatch in reset: wb_valid %h bfs_req %h uart_tx_valid %h req_full %h",
                 wb_valid, uut.bfs_req, uart_tx_valid, req_full);
        err_count++;
      end
      cycle_nxt   = 64'h0;
      instret_nxt = 64'h0;
      m_uart      = 8'h0;
      m_root      = 32'h0;
      m_targ      = 32'h0;
      m_qbase     = 32'h0;
      m_qsize     = 32'h0;
    end else begin
      if (req_full)
        full_seen = 1'b1;
      // queue is full exactly when the stage and all queue slots are occupied
      exp_full = (in_flight > FIFO_DEPTH);
      if (req_full !== exp_full) begin
        $display("Mismatch req_full: got %h expected %h (%0d outstanding)",
                 req_full, exp_full, in_flight);
        err_count++;
      end
      if (wb_valid === 1'b1 && exp_q.size() == 0) begin
        $display("writeback at cycle %0d with no instruction outstanding", cyc);
        err_count++;
      end else if (wb_valid === 1'b1) begin
        {op, addr, op1, rb, rdv} = exp_q.pop_front();
        wr         = (op != csr_read);
        exp_err    = 1'b0;
        chk_result = 1'b1;
        old_val    = 32'h0;
        case (addr)
          addr_mcycle:    old_val = m_cycle[31:0];
          addr_mcycleh:   old_val = m_cycle[63:32];
          addr_minstret:  old_val = m_instret[31:0];
          addr_minstreth: old_val = m_instret[63:32];
          addr_muartstat: begin
            old_val = uartstat_value;
            exp_err = wr;
          end
          addr_muarttx:   old_val = {24'h0, m_uart};
          addr_ml2stat:   old_val = {31'h0, l2_req};
          default: begin
            if (addr[11:4] != 8'h7D || op == csr_rs || op == csr_rc) begin
              exp_err    = 1'b1;
              chk_result = 1'b0;
            end else begin
              case (addr[3:0])
                4'd0: begin
                  old_val = {31'h0, m_root != m_targ};
                  exp_err = wr;
                end
                4'd1:    old_val = m_root;
                4'd2:    old_val = m_targ;
                4'd3:    old_val = m_qbase;
                4'd4:    old_val = m_qsize;
                default: exp_err = 1'b1;
              endcase
            end
          end
        endcase
        case (op)
          csr_rw:  new_val = op1;
          csr_rs:  new_val = old_val | op1;
          csr_rc:  new_val = old_val & ~op1;
          default: new_val = old_val;
        endcase
        if (wb_robid !== rb) begin
          $display("Mismatch wb_robid: got %h expected %h", wb_robid, rb);
          err_count++;
        end
        if (wb_rd !== rdv) begin
          $display("Mismatch wb_rd: got %h expected %h (robid %h)", wb_rd, rdv, rb);
          err_count++;
        end
        if (wb_error !== exp_err) begin
          $display("Mismatch wb_error: got %h expected %h (addr %h)", wb_error, exp_err, addr);
          err_count++;
        end
        if (chk_result && wb_result !== old_val) begin
          $display("Mismatch wb_result: got %h expected %h (addr %h)", wb_result, old_val, addr);
          err_count++;
        end
        if (wr && addr == addr_ml2stat && l2_req) begin
          $display("ML2STAT write with robid %h retired while l2_req was high", rb);
          err_count++;
        end
        if (wr && !exp_err) begin
          case (addr)
            addr_mcycle:    cycle_nxt[31:0] = new_val;
            addr_mcycleh:   cycle_nxt[63:32] = new_val;
            addr_minstret: begin
              // the csr write's own retire is not counted
              instret_nxt       = m_instret + {63'h0, rob_ret_valid & ~rob_ret_csr};
              instret_nxt[31:0] = new_val;
            end
            addr_minstreth: instret_nxt[63:32] = new_val;
            addr_muarttx: begin
              m_uart = new_val[7:0];
              exp_tx = 1'b1;
            end
            addr_mbfsroot:  m_root = new_val;
            addr_mbfstarg:  m_targ = new_val;
            addr_mbfsqbase: m_qbase = new_val;
            addr_mbfsqsize: m_qsize = new_val;
            default: ;
          endcase
        end
        in_flight--;
        done_cnt++;
      end
      if (uart_tx_valid !== exp_tx) begin
        $display("Mismatch uart_tx_valid: got %h expected %h", uart_tx_valid, exp_tx);
        err_count++;
      end else if (exp_tx && uart_tx_data !== m_uart) begin
        $display("Mismatch uart_tx_data: got %h expected %h", uart_tx_data, m_uart);
        err_count++;
      end
      if (req_valid) begin
        exp_q.push_back({req_op, req_imm[11:0], req_op1, req_robid, req_rd});
        sent++;
        in_flight++;
      end
    end
    m_cycle   = cycle_nxt;
    m_instret = instret_nxt;
  endtask

  initial begin
    seed          = 32'ha9bc_e6e7;
    err_count     = 0;
    sent          = 0;
    done_cnt      = 0;
    in_flight     = 0;
    cyc           = 0;
    full_seen     = 1'b0;
    rst           = 1'b1;
    req_valid     = 1'b0;
    req_op        = csr_read;
    req_robid     = '0;
    req_rd        = '0;
    req_op1       = 32'h0;
    req_imm       = 32'h0;
    rob_ret_valid = 1'b0;
    rob_ret_csr   = 1'b0;
    l2_req        = 1'b0;
    while (!(sent == NUM_INSTR && in_flight == 0) && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
      if (cyc >= 8)
        rst = 1'b0;
      drive_inputs();
      #1;
      model_cycle();
    end
    if (sent != NUM_INSTR || in_flight != 0) begin
      $display("timeout after %0d cycles with %0d of %0d written back", cyc, done_cnt, NUM_INSTR);
      err_count++;
    end
    if (!full_seen) begin
      $display("req_full never rose during the run");
      err_count++;
    end
    $display("csr_tb: %0d sent, %0d written back, %0d errors", sent, done_cnt, err_count);
    if (err_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: compile.f
hdl/csr_pkg.sv
hdl/csr_req_fifo.sv
hdl/csr_unit.sv
hdl/bfs_csr_regs.sv
hdl/csr_top.sv
tb/csr_sva.sv
tb/csr_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module csr_tb -f compile.f -o csr_sim || exit 1
./obj_dir/csr_sim > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
